/* design/dds_regs_pkg.sv */
`default_nettype none

package dds_regs_pkg;

    // ----------------------------------------
    // Register map, byte addresses
    // ----------------------------------------
    localparam logic [11:0] reg_am_mux      = 12'h00;
    localparam logic [11:0] reg_am_raw      = 12'h04;
    localparam logic [11:0] reg_am_gain     = 12'h08;
    localparam logic [11:0] reg_am_offset   = 12'h0C;

    localparam logic [11:0] reg_fm_mux      = 12'h10;
    localparam logic [11:0] reg_fm_raw      = 12'h14;
    localparam logic [11:0] reg_fm_gain     = 12'h18;
    localparam logic [11:0] reg_fm_offset   = 12'h1C;

    localparam logic [11:0] reg_pm_mux      = 12'h20;
    localparam logic [11:0] reg_pm_raw      = 12'h24;
    localparam logic [11:0] reg_pm_gain     = 12'h28;
    localparam logic [11:0] reg_pm_offset   = 12'h2C;

    localparam logic [11:0] reg_mux         = 12'h30;
    localparam logic [11:0] reg_raw         = 12'h34;
    localparam logic [11:0] reg_rom         = 12'h38;
    localparam logic [11:0] reg_step        = 12'h3C;
    localparam logic [11:0] reg_prbs_gain   = 12'h40;
    localparam logic [11:0] reg_prbs_offset = 12'h44;

    localparam logic [11:0] reg_stat_cfg    = 12'h48; // Bit 0 enable, bit 1 clear
    localparam logic [11:0] reg_stat_min    = 12'h4C;
    localparam logic [11:0] reg_stat_max    = 12'h50;
    localparam logic [11:0] reg_stat_limit  = 12'h54;
    localparam logic [11:0] reg_stat_count  = 12'h58;

    // ----------------------------------------
    // Bus request and configuration
    // ----------------------------------------
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [3:0]  sel;    // Source code, see dds_signal_pkg
        logic [31:0] raw;
        logic [31:0] gain;   // Only the low 16 bits scale the source
        logic [31:0] offset;
    } mod_cfg_t;

    typedef struct packed {
        logic [3:0]  out_sel;
        logic [31:0] raw;
        logic [31:0] step;
        logic [7:0]  rom_data;
        logic        rom_wr; // One cycle per table write
        logic [15:0] prbs_gain;
        logic [7:0]  prbs_offset;
    } gen_cfg_t;

    typedef struct packed {
        logic        enable;
        logic        clear;
        logic [31:0] limit;  // Zero means no limit
    } stat_cfg_t;

    localparam stat_cfg_t stat_cfg_rst = '{enable: 1'b1, clear: 1'b0, limit: 32'h0};

endpackage

`default_nettype wire

/* design/dds_signal_pkg.sv */
`default_nettype none

package dds_signal_pkg;

    // ----------------------------------------
    // Data path widths
    // ----------------------------------------
    localparam int sample_w    = 8;
    localparam int phase_w     = 32;
    localparam int table_depth = 256;
    localparam int table_aw    = 8;  // Top phase bits that address the table

    // ----------------------------------------
    // Modulation source codes
    // ----------------------------------------
    localparam logic [3:0] src_raw  = 4'd0;
    localparam logic [3:0] src_prbs = 4'd1;
    localparam logic [3:0] src_wave = 4'd2;

    // ----------------------------------------
    // Output select codes
    // ----------------------------------------
    localparam logic [3:0] out_wave = 4'd0;
    localparam logic [3:0] out_raw  = 4'd1;
    localparam logic [3:0] out_prbs = 4'd2;

    // Running statistics of the output sample
    typedef struct packed {
        logic [sample_w-1:0] min;
        logic [sample_w-1:0] max;
        logic [31:0]         count;
    } stat_t;

    localparam stat_t stat_rst = '{
        min:   {sample_w{1'b1}},
        max:   {sample_w{1'b0}},
        count: 32'h0
    };

endpackage

`default_nettype wire

/* design/dds_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module dds_regs
    import dds_regs_pkg::*, dds_signal_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  apb_req_t    req,
    input  stat_t       stats,
    output logic [31:0] prdata,
    output mod_cfg_t    am_cfg,
    output mod_cfg_t    fm_cfg,
    output mod_cfg_t    pm_cfg,
    output gen_cfg_t    gen_cfg,
    output stat_cfg_t   stat_cfg
);

    logic [11:0] addr;
    logic        wr_en;

    assign addr  = {req.paddr[11:2], 2'b00}; // Word aligned register offset
    assign wr_en = req.psel && req.penable && req.pwrite;

    // ----------------------------------------
    // Write side
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            am_cfg   <= '0;
            fm_cfg   <= '0;
            pm_cfg   <= '0;
            gen_cfg  <= '0;
            stat_cfg <= stat_cfg_rst;
        end else begin
            gen_cfg.rom_wr <= 1'b0; // Pulse drops unless written again

            if (wr_en) begin
                case (addr)
                    reg_am_mux:      am_cfg.sel    <= req.pwdata[3:0];
                    reg_am_raw:      am_cfg.raw    <= req.pwdata;
                    reg_am_gain:     am_cfg.gain   <= req.pwdata;
                    reg_am_offset:   am_cfg.offset <= req.pwdata;

                    reg_fm_mux:      fm_cfg.sel    <= req.pwdata[3:0];
                    reg_fm_raw:      fm_cfg.raw    <= req.pwdata;
                    reg_fm_gain:     fm_cfg.gain   <= req.pwdata;
                    reg_fm_offset:   fm_cfg.offset <= req.pwdata;

                    reg_pm_mux:      pm_cfg.sel    <= req.pwdata[3:0];
                    reg_pm_raw:      pm_cfg.raw    <= req.pwdata;
                    reg_pm_gain:     pm_cfg.gain   <= req.pwdata;
                    reg_pm_offset:   pm_cfg.offset <= req.pwdata;

                    reg_mux:         gen_cfg.out_sel     <= req.pwdata[3:0];
                    reg_raw:         gen_cfg.raw         <= req.pwdata;
                    reg_step:        gen_cfg.step        <= req.pwdata;
                    reg_prbs_gain:   gen_cfg.prbs_gain   <= req.pwdata[15:0];
                    reg_prbs_offset: gen_cfg.prbs_offset <= req.pwdata[7:0];

                    reg_rom: begin
                        gen_cfg.rom_data <= req.pwdata[7:0];
                        gen_cfg.rom_wr   <= 1'b1;
                    end

                    reg_stat_cfg: begin
                        stat_cfg.enable <= req.pwdata[0];
                        stat_cfg.clear  <= req.pwdata[1];
                    end

                    reg_stat_limit:  stat_cfg.limit <= req.pwdata;

                    default: ;
                endcase
            end
        end
    end

    // ----------------------------------------
    // Read side
    // ----------------------------------------

    // Only the statistics come back, with no wait state
    always_comb begin
        case (addr)
            reg_stat_min:   prdata = {{(32-sample_w){1'b0}}, stats.min};
            reg_stat_max:   prdata = {{(32-sample_w){1'b0}}, stats.max};
            reg_stat_count: prdata = stats.count;
            default:        prdata = 32'h0;
        endcase
    end

endmodule

`default_nettype wire

/* design/dds_modulator.sv */
`timescale 1ns/1ps
`default_nettype none

// Scaled and offset modulation value, one instance each for AM, FM and PM
module dds_modulator
    import dds_regs_pkg::*, dds_signal_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  mod_cfg_t            cfg,
    input  logic [sample_w-1:0] prbs_sample,
    input  logic [sample_w-1:0] wave_sample,
    output logic [31:0]         value
);

    logic [31:0] source;
    logic [47:0] scaled;

    // ----------------------------------------
    // Source select
    // ----------------------------------------
    always_comb begin
        case (cfg.sel)
            src_raw:  source = cfg.raw;
            src_prbs: source = {{(32-sample_w){1'b0}}, prbs_sample};
            src_wave: source = {{(32-sample_w){1'b0}}, wave_sample};
            default:  source = 32'h0; // Unknown codes contribute nothing
        endcase
    end

    // Gain is a 16.16 fraction, so full scale is just below one
    assign scaled = source * cfg.gain[15:0];

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            value <= 32'h0;
        end else begin
            value <= scaled[47:16] + cfg.offset; // Wraps at 32 bits
        end
    end

endmodule

`default_nettype wire

/* design/dds_core.sv */
`timescale 1ns/1ps
`default_nettype none

module dds_core
    import dds_regs_pkg::*, dds_signal_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  mod_cfg_t            am_cfg,
    input  mod_cfg_t            fm_cfg,
    input  mod_cfg_t            pm_cfg,
    input  gen_cfg_t            gen_cfg,
    output logic [sample_w-1:0] wave_sample,
    output logic [sample_w-1:0] prbs_sample
);

    logic [31:0]         am_value;
    logic [31:0]         fm_value;
    logic [31:0]         pm_value;
    logic [phase_w-1:0]  phase;
    logic [phase_w-1:0]  phase_pm;
    logic [table_aw-1:0] table_addr;
    logic [table_aw-1:0] wr_ptr;
    logic [sample_w-1:0] wave_table [table_depth];
    logic [sample_w-1:0] table_q;
    logic [39:0]         am_prod;
    logic [6:0]          lfsr;
    logic [22:0]         prbs_scaled;

    dds_modulator u_am (.clk, .reset, .cfg(am_cfg), .prbs_sample, .wave_sample, .value(am_value));
    dds_modulator u_fm (.clk, .reset, .cfg(fm_cfg), .prbs_sample, .wave_sample, .value(fm_value));
    dds_modulator u_pm (.clk, .reset, .cfg(pm_cfg), .prbs_sample, .wave_sample, .value(pm_value));

    // ----------------------------------------
    // Phase accumulator
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
        end else begin
            phase <= phase + gen_cfg.step + fm_value; // FM adds to the step
        end
    end

    assign phase_pm   = phase + pm_value;
    assign table_addr = phase_pm[phase_w-1 -: table_aw];

    // ----------------------------------------
    // Waveform table
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (gen_cfg.rom_wr) begin
            wr_ptr <= wr_ptr + 1'b1; // Wraps after the last entry
        end
    end

    always_ff @(posedge clk) begin
        if (gen_cfg.rom_wr) begin
            wave_table[wr_ptr] <= gen_cfg.rom_data;
        end
        table_q <= wave_table[table_addr];
    end

    // AM value is 16.16, 0x10000 passes the table sample unchanged
    assign am_prod = table_q * am_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            wave_sample <= '0;
        end else if (|am_prod[39:24]) begin
            wave_sample <= {sample_w{1'b1}};
        end else begin
            wave_sample <= am_prod[23:16];
        end
    end

    // ----------------------------------------
    // PRBS7 noise, x^7 + x^6 + 1
    // ----------------------------------------
    assign prbs_scaled = lfsr * gen_cfg.prbs_gain;

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr        <= 7'h7F;
            prbs_sample <= '0;
        end else begin
            lfsr        <= {lfsr[5:0], lfsr[6] ^ lfsr[5]};
            prbs_sample <= prbs_scaled[15:8] + gen_cfg.prbs_offset;
        end
    end

endmodule

`default_nettype wire

/* design/dds_output.sv */
`timescale 1ns/1ps
`default_nettype none

module dds_output
    import dds_regs_pkg::*, dds_signal_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  gen_cfg_t            gen_cfg,
    input  stat_cfg_t           stat_cfg,
    input  logic [sample_w-1:0] wave_sample,
    input  logic [sample_w-1:0] prbs_sample,
    output logic [sample_w-1:0] sample,
    output stat_t               stats
);

    logic [sample_w-1:0] sample_sel;
    logic                count_open;

    // ----------------------------------------
    // Output select
    // ----------------------------------------
    always_comb begin
        case (gen_cfg.out_sel)
            out_wave: sample_sel = wave_sample;
            out_raw:  sample_sel = gen_cfg.raw[sample_w-1:0];
            out_prbs: sample_sel = prbs_sample;
            default:  sample_sel = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sample <= '0;
        end else begin
            sample <= sample_sel;
        end
    end

    // ----------------------------------------
    // Statistics
    // ----------------------------------------

    // A zero limit lets the count run freely
    assign count_open = (stat_cfg.limit == 32'h0) || (stats.count < stat_cfg.limit);

    always_ff @(posedge clk) begin
        if (reset || stat_cfg.clear) begin
            stats <= stat_rst;
        end else if (stat_cfg.enable && count_open) begin
            if (sample < stats.min) begin
                stats.min <= sample;
            end
            if (sample > stats.max) begin
                stats.max <= sample;
            end
            stats.count <= stats.count + 32'd1;
        end
    end

endmodule

`default_nettype wire

/* design/dds_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dds_top
    import dds_regs_pkg::*, dds_signal_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  apb_req_t            req,
    output logic [31:0]         prdata,
    output logic [sample_w-1:0] sample
);

    mod_cfg_t            am_cfg;
    mod_cfg_t            fm_cfg;
    mod_cfg_t            pm_cfg;
    gen_cfg_t            gen_cfg;
    stat_cfg_t           stat_cfg;
    stat_t               stats;
    logic [sample_w-1:0] wave_sample;
    logic [sample_w-1:0] prbs_sample;

    // ----------------------------------------
    // Control
    // ----------------------------------------
    dds_regs u_regs (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .stats    (stats),
        .prdata   (prdata),
        .am_cfg   (am_cfg),
        .fm_cfg   (fm_cfg),
        .pm_cfg   (pm_cfg),
        .gen_cfg  (gen_cfg),
        .stat_cfg (stat_cfg)
    );

    // ----------------------------------------
    // Signal path
    // ----------------------------------------
    dds_core u_core (
        .clk         (clk),
        .reset       (reset),
        .am_cfg      (am_cfg),
        .fm_cfg      (fm_cfg),
        .pm_cfg      (pm_cfg),
        .gen_cfg     (gen_cfg),
        .wave_sample (wave_sample),
        .prbs_sample (prbs_sample)
    );

    dds_output u_output (
        .clk         (clk),
        .reset       (reset),
        .gen_cfg     (gen_cfg),
        .stat_cfg    (stat_cfg),
        .wave_sample (wave_sample),
        .prbs_sample (prbs_sample),
        .sample      (sample),
        .stats       (stats)
    );

endmodule

`default_nettype wire

/* tests/dds_top_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module dds_top_sva
    import dds_signal_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        rom_wr,
    input stat_t       stats,
    input logic [31:0] limit
);

    int fail_count = 0; // Number of failed assertions so far

    rom_wr_single: assert property (@(posedge clk) disable iff (reset) rom_wr |=> !rom_wr)
        else begin
            fail_count++;
            $error("table write pulse lasted two cycles");
        end

    // Once a sample is counted the range cannot be inverted
    min_below_max: assert property (@(posedge clk) disable iff (reset)
        stats.count != 0 |-> stats.min <= stats.max)
        else begin
            fail_count++;
            $error("stat min above stat max");
        end

    count_in_limit: assert property (@(posedge clk) disable iff (reset)
        limit != 0 |-> stats.count <= limit)
        else begin
            fail_count++;
            $error("stat count beyond its limit");
        end

endmodule

bind dds_top dds_top_sva u_sva (
    .clk    (clk),
    .reset  (reset),
    .rom_wr (gen_cfg.rom_wr),
    .stats  (stats),
    .limit  (stat_cfg.limit)
);

`default_nettype wire

/* tests/tb_dds_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dds_top
    import dds_regs_pkg::*, dds_signal_pkg::*;
();

    typedef struct packed {
        logic [11:0] addr;
        logic [31:0] data;
    } reg_write_t;

    logic        clk;
    logic        reset;
    apb_req_t    req;
    logic [31:0] prdata;
    logic [7:0]  sample;

    // ----------------------------------------
    // Stimulus and expected-value table
    // ----------------------------------------
    string       t_name  [20];
    bit          t_rst   [20]; // Reset the DUT just before the check
    bit          t_read  [20]; // Register read check, else a sample check
    logic [11:0] t_raddr [20];
    logic [31:0] t_exp   [20];
    int          t_tries [20]; // One try means the value must match at once
    int          t_nwr   [20];
    reg_write_t  t_wr    [20][6];
    int          n_entries;

    logic [7:0]  rom_image [table_depth];
    integer      seed;

    dds_top DUT (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .prdata (prdata),
        .sample (sample)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // APB access
    // ----------------------------------------
    task automatic release_bus();
        @(posedge clk);
        #2;
        req = '0;
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = 1'b1;
        req.paddr   = {20'h0, addr};
        req.pwdata  = data;
        @(posedge clk);
        #2;
        req.penable = 1'b1; // Register updates on the next edge
        release_bus();
    endtask

    // Read data is sampled late in the access cycle
    task automatic read_reg(input logic [11:0] addr, input bit drop_reset,
                            output logic [31:0] data);
        @(posedge clk);
        #2;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = 1'b0;
        req.paddr   = {20'h0, addr};
        @(posedge clk);
        #2;
        req.penable = 1'b1;
        if (drop_reset) begin
            reset = 1'b0;
        end
        #8;
        data = prdata;
    endtask

    task automatic new_entry(input string name, input bit rst, input bit rd,
                             input logic [11:0] raddr, input logic [31:0] exp,
                             input int tries);
        t_name[n_entries]  = name;
        t_rst[n_entries]   = rst;
        t_read[n_entries]  = rd;
        t_raddr[n_entries] = raddr;
        t_exp[n_entries]   = exp;
        t_tries[n_entries] = tries;
        t_nwr[n_entries]   = 0;
        n_entries++;
    endtask

    task automatic push_write(input logic [11:0] addr, input logic [31:0] data);
        t_wr[n_entries-1][t_nwr[n_entries-1]] = '{addr: addr, data: data};
        t_nwr[n_entries-1]++;
    endtask

    task automatic load_table();
        int k;
        for (k = 0; k < table_depth; k++) begin
            rom_image[k] = 8'($random(seed));
        end
        rom_image[7] = 8'd200; // Entry used by the AM checks
        for (k = 0; k < table_depth; k++) begin
            write_reg(reg_rom, {24'h0, rom_image[k]});
        end
    endtask

    task automatic build_table();
        new_entry("reset_min", 1, 1, reg_stat_min, 32'hFF, 1);
        new_entry("reset_max", 1, 1, reg_stat_max, 32'h00, 1);
        push_write(reg_raw, 32'hA5);
        push_write(reg_mux, {28'h0, out_raw});
        new_entry("reset_count", 1, 1, reg_stat_count, 32'h0, 1);
        new_entry("reset_sample", 1, 0, reg_stat_min, 32'h0, 1);
        push_write(reg_raw, 32'h6E);
        push_write(reg_mux, {28'h0, out_raw});
        new_entry("raw_5a", 0, 0, 12'h0, 32'h5A, 50);
        push_write(reg_raw, 32'h5A);
        push_write(reg_mux, {28'h0, out_raw});
        new_entry("raw_c3", 0, 0, 12'h0, 32'hC3, 50);
        push_write(reg_raw, 32'hC3);
        new_entry("table_0", 0, 0, 12'h0, {24'h0, rom_image[0]}, 50);
        push_write(reg_mux, {28'h0, out_wave});
        push_write(reg_step, 32'h0);
        push_write(reg_am_gain, 32'h0);
        push_write(reg_am_offset, 32'h0001_0000); // Unity amplitude
        push_write(reg_pm_gain, 32'h0);
        push_write(reg_pm_offset, 32'h0);
        new_entry("table_5", 0, 0, 12'h0, {24'h0, rom_image[5]}, 50);
        push_write(reg_pm_offset, 32'h0500_0000);
        new_entry("table_255", 0, 0, 12'h0, {24'h0, rom_image[255]}, 50);
        push_write(reg_pm_offset, 32'hFF00_0000);
        new_entry("am_half", 0, 0, 12'h0, 32'd100, 50); // 200 times one half
        push_write(reg_pm_offset, 32'h0700_0000);
        push_write(reg_am_offset, 32'h0000_8000);
        new_entry("am_saturate", 0, 0, 12'h0, 32'd255, 50);
        push_write(reg_am_offset, 32'h0002_0000);
        new_entry("prbs_offset", 0, 0, 12'h0, 32'h37, 50);
        push_write(reg_mux, {28'h0, out_prbs});
        push_write(reg_prbs_gain, 32'h0);
        push_write(reg_prbs_offset, 32'h37);
        new_entry("stat_count", 0, 1, reg_stat_count, 32'd5, 50);
        push_write(reg_raw, 32'h40);
        push_write(reg_mux, {28'h0, out_raw});
        push_write(reg_stat_cfg, 32'h2);
        push_write(reg_stat_limit, 32'd5);
        push_write(reg_stat_cfg, 32'h1);
        new_entry("stat_min", 0, 1, reg_stat_min, 32'h40, 1);
        new_entry("stat_max", 0, 1, reg_stat_max, 32'h40, 1);
        new_entry("stat_hold", 0, 1, reg_stat_count, 32'd5, 1);
        new_entry("unmapped", 0, 1, 12'h5C, 32'h0, 1);
    endtask

    // ----------------------------------------
    // Entry execution
    // ----------------------------------------
    task automatic apply_entry(input int i);
        logic [31:0] data;
        int          tries;
        int          w;
        // Writes come before a reset so that the reset has state to clear
        for (w = 0; w < t_nwr[i]; w++) begin
            write_reg(t_wr[i][w].addr, t_wr[i][w].data);
        end
        if (t_rst[i]) begin
            repeat (2) @(posedge clk); // Statistics take in the new sample first
            #2;
            reset = 1'b1;
            repeat (2) @(posedge clk);
            read_reg(t_raddr[i], 1'b1, data); // Reset drops as the access starts
        end
        tries = 1;
        if (t_read[i]) begin
            if (!t_rst[i]) begin
                read_reg(t_raddr[i], 1'b0, data);
            end
            while (data !== t_exp[i] && tries < t_tries[i]) begin
                read_reg(t_raddr[i], 1'b0, data);
                tries++;
            end
        end else begin
            while (sample !== t_exp[i][7:0] && tries < t_tries[i]) begin
                @(posedge clk);
                #2;
                tries++;
            end
            data = {24'h0, sample};
        end
        if (t_tries[i] > 1 && data !== t_exp[i]) begin
            $display("Timeout in %s: no match after %0d tries", t_name[i], tries);
        end
        check_value(t_name[i], t_exp[i], data);
        release_bus();
        if (DUT.u_sva.fail_count != 0) begin
            $display("An assertion failed during %s", t_name[i]);
            abort_run();
        end
    endtask

    initial begin
        int i;
        seed      = 32'hd5cf;
        reset     = 1'b1;
        req       = '0;
        n_entries = 0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        load_table();
        build_table();
        for (i = 0; i < n_entries; i++) begin
            apply_entry(i);
        end
        if (DUT.u_sva.fail_count != 0) begin
            abort_run();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* files.f */
design/dds_regs_pkg.sv
design/dds_signal_pkg.sv
design/dds_regs.sv
design/dds_modulator.sv
design/dds_core.sv
design/dds_output.sv
design/dds_top.sv
tests/dds_top_sva.sv
tests/tb_dds_top.sv
